//--- common/cpu_pkg.sv
package cpu_pkg;

    // **************************************************
    // Sizes
    // **************************************************
    localparam int data_width     = 16;
    localparam int instr_width    = 16;
    localparam int reg_addr_width = 3;                 // Eight registers.
    localparam int imem_depth     = 256;
    localparam int dmem_depth     = 256;
    localparam int mem_addr_width = 8;
    localparam int imm_width      = 9;                 // LDI immediate, bits 8 to 0.
    localparam int shamt_width    = $clog2(data_width);

    // **************************************************
    // Instruction encoding
    // **************************************************
    typedef enum logic [3:0] {
        op_nop = 4'h0,
        op_add = 4'h1,
        op_sub = 4'h2,
        op_and = 4'h3,
        op_or  = 4'h4,
        op_xor = 4'h5,
        op_not = 4'h6,
        op_shl = 4'h7,
        op_shr = 4'h8,
        op_ldi = 4'h9,
        op_ld  = 4'ha,
        op_st  = 4'hb
    } opcode_t;

    // Bubble word injected by fetch.
    localparam logic [instr_width-1:0] nop_instr = {op_nop, {(instr_width - 4){1'b0}}};

    // **************************************************
    // ALU operations
    // **************************************************
    typedef enum logic [3:0] {
        alu_add    = 4'h0,
        alu_sub    = 4'h1,
        alu_and    = 4'h2,
        alu_or     = 4'h3,
        alu_xor    = 4'h4,
        alu_not    = 4'h5,
        alu_shl    = 4'h6,
        alu_shr    = 4'h7,
        alu_pass_a = 4'h8,                             // Address for LD and ST.
        alu_pass_b = 4'h9                              // Immediate for LDI.
    } alu_op_t;

endpackage

//--- decode/decode_stage.sv
module decode_stage (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic [cpu_pkg::instr_width-1:0]    instr,
    input  logic                              instr_valid,
    input  logic                              wb_valid,
    input  logic [cpu_pkg::reg_addr_width-1:0] wb_dest,
    input  logic [cpu_pkg::data_width-1:0]     wb_output,
    output logic [cpu_pkg::data_width-1:0]     rs_data,
    output logic [cpu_pkg::data_width-1:0]     rt_data,
    output logic [cpu_pkg::data_width-1:0]     imm,
    output cpu_pkg::alu_op_t                  alu_op,
    output logic                              use_imm,
    output logic                              mem_read,
    output logic                              mem_write,
    output logic                              reg_write,
    output logic [cpu_pkg::reg_addr_width-1:0] dest
);
    import cpu_pkg::*;

    opcode_t                   opcode;
    logic [reg_addr_width-1:0] rd_field;
    logic [reg_addr_width-1:0] rs_field;
    logic [reg_addr_width-1:0] rt_field;
    logic [data_width-1:0]     rf_rs_data;
    logic [data_width-1:0]     rf_rt_data;
    logic [data_width-1:0]     imm_ext;
    alu_op_t                   alu_op_c;
    logic                      use_imm_c;
    logic                      mem_read_c;
    logic                      mem_write_c;
    logic                      reg_write_c;

    assign opcode   = opcode_t'(instr[15:12]);
    assign rd_field = instr[11:9];
    assign rs_field = instr[8:6];
    assign rt_field = instr[5:3];
    assign imm_ext  = {{(data_width - imm_width){1'b0}}, instr[imm_width-1:0]};

    register_file rf0 (
        .clk     (clk),
        .arst_n  (arst_n),
        .rs_addr (rs_field),
        .rt_addr (rt_field),
        .we      (wb_valid),
        .wr_addr (wb_dest),
        .wr_data (wb_output),
        .rs_data (rf_rs_data),
        .rt_data (rf_rt_data)
    );

    // **************************************************
    // Control decode
    // **************************************************
    always_comb begin
        alu_op_c    = alu_pass_a;
        use_imm_c   = 1'b0;
        mem_read_c  = 1'b0;
        mem_write_c = 1'b0;
        reg_write_c = 1'b0;
        if (instr_valid) begin
            case (opcode)
                op_add: begin alu_op_c = alu_add; reg_write_c = 1'b1; end
                op_sub: begin alu_op_c = alu_sub; reg_write_c = 1'b1; end
                op_and: begin alu_op_c = alu_and; reg_write_c = 1'b1; end
                op_or:  begin alu_op_c = alu_or;  reg_write_c = 1'b1; end
                op_xor: begin alu_op_c = alu_xor; reg_write_c = 1'b1; end
                op_not: begin alu_op_c = alu_not; reg_write_c = 1'b1; end
                op_shl: begin alu_op_c = alu_shl; reg_write_c = 1'b1; end
                op_shr: begin alu_op_c = alu_shr; reg_write_c = 1'b1; end
                op_ldi: begin
                    alu_op_c    = alu_pass_b;
                    use_imm_c   = 1'b1;
                    reg_write_c = 1'b1;
                end
                op_ld: begin
                    mem_read_c  = 1'b1;                  // Address is rs.
                    reg_write_c = 1'b1;
                end
                op_st:   mem_write_c = 1'b1;
                default: ;                                // NOP and unused codes.
            endcase
        end
    end

    // Decode/execute register.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            alu_op    <= alu_pass_a;
            use_imm   <= 1'b0;
            mem_read  <= 1'b0;
            mem_write <= 1'b0;
            reg_write <= 1'b0;
        end else begin
            alu_op    <= alu_op_c;
            use_imm   <= use_imm_c;
            mem_read  <= mem_read_c;
            mem_write <= mem_write_c;
            reg_write <= reg_write_c;
        end
    end

    always_ff @(posedge clk) begin
        rs_data <= rf_rs_data;
        rt_data <= rf_rt_data;
        imm     <= imm_ext;
        dest    <= rd_field;
    end

endmodule

//--- decode/register_file.sv
module register_file (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic [cpu_pkg::reg_addr_width-1:0] rs_addr,
    input  logic [cpu_pkg::reg_addr_width-1:0] rt_addr,
    input  logic                              we,
    input  logic [cpu_pkg::reg_addr_width-1:0] wr_addr,
    input  logic [cpu_pkg::data_width-1:0]     wr_data,
    output logic [cpu_pkg::data_width-1:0]     rs_data,
    output logic [cpu_pkg::data_width-1:0]     rt_data
);
    import cpu_pkg::*;

    localparam int num_regs = 2 ** reg_addr_width;

    logic [data_width-1:0] regs [num_regs];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Write-before-read bypass.
    assign rs_data = (we && (wr_addr == rs_addr)) ? wr_data : regs[rs_addr];
    assign rt_data = (we && (wr_addr == rt_addr)) ? wr_data : regs[rt_addr];

endmodule

//--- fetch/fetch_stage.sv
module fetch_stage (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              run,
    input  logic                              prog_we,
    input  logic [cpu_pkg::mem_addr_width-1:0] prog_addr,
    input  logic [cpu_pkg::instr_width-1:0]    prog_data,
    output logic [cpu_pkg::instr_width-1:0]    instr,
    output logic                              instr_valid
);
    import cpu_pkg::*;

    logic [instr_width-1:0]    imem [imem_depth];
    logic [mem_addr_width-1:0] pc;
    logic                      run_q;

    // Load port, closed while the core runs.
    always_ff @(posedge clk) begin
        if (prog_we && !run) begin
            imem[prog_addr] <= prog_data;
        end
    end

    // **************************************************
    // PC and fetch/decode register
    // **************************************************
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            run_q       <= 1'b0;
            pc          <= '0;
            instr       <= nop_instr;
            instr_valid <= 1'b0;
        end else begin
            run_q <= run;
            if (run && run_q) begin
                instr       <= imem[pc];
                instr_valid <= 1'b1;
                pc          <= pc + 1'b1;                 // One word per cycle.
            end else begin
                instr       <= nop_instr;                 // Bubble.
                instr_valid <= 1'b0;
                pc          <= '0;                        // Restart from address 0.
            end
        end
    end

endmodule

//--- hdl/alu_stage.sv
module alu_stage (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic [cpu_pkg::data_width-1:0]     rs_data,
    input  logic [cpu_pkg::data_width-1:0]     rt_data,
    input  logic [cpu_pkg::data_width-1:0]     imm,
    input  cpu_pkg::alu_op_t                  alu_op,
    input  logic                              use_imm,
    input  logic                              mem_read,
    input  logic                              mem_write,
    input  logic                              reg_write,
    input  logic [cpu_pkg::reg_addr_width-1:0] dest,
    output logic [cpu_pkg::data_width-1:0]     result,
    output logic [cpu_pkg::data_width-1:0]     store_data,
    output logic                              mem_read_q,
    output logic                              mem_write_q,
    output logic                              reg_write_q,
    output logic [cpu_pkg::reg_addr_width-1:0] dest_q
);
    import cpu_pkg::*;

    logic [data_width-1:0]  op_a;
    logic [data_width-1:0]  op_b;
    logic [shamt_width-1:0] shamt;
    logic [data_width-1:0]  alu_out;

    assign op_a  = rs_data;
    assign op_b  = use_imm ? imm : rt_data;
    assign shamt = op_b[shamt_width-1:0];             // Low bits of rt.

    always_comb begin
        case (alu_op)
            alu_add:    alu_out = op_a + op_b;
            alu_sub:    alu_out = op_a - op_b;
            alu_and:    alu_out = op_a & op_b;
            alu_or:     alu_out = op_a | op_b;
            alu_xor:    alu_out = op_a ^ op_b;
            alu_not:    alu_out = ~op_a;
            alu_shl:    alu_out = op_a << shamt;
            alu_shr:    alu_out = op_a >> shamt;
            alu_pass_b: alu_out = op_b;
            default:    alu_out = op_a;
        endcase
    end

    // Execute/memory register.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_read_q  <= 1'b0;
            mem_write_q <= 1'b0;
            reg_write_q <= 1'b0;
        end else begin
            mem_read_q  <= mem_read;
            mem_write_q <= mem_write;
            reg_write_q <= reg_write;
        end
    end

    always_ff @(posedge clk) begin
        result     <= alu_out;
        store_data <= rt_data;                        // ST data.
        dest_q     <= dest;
    end

endmodule

//--- hdl/data_memory.sv
module data_memory (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic [cpu_pkg::data_width-1:0]     result,
    input  logic [cpu_pkg::data_width-1:0]     store_data,
    input  logic                              mem_read,
    input  logic                              mem_write,
    input  logic                              reg_write,
    input  logic [cpu_pkg::reg_addr_width-1:0] dest,
    output logic                              wb_valid,
    output logic [cpu_pkg::reg_addr_width-1:0] wb_dest,
    output logic [cpu_pkg::data_width-1:0]     wb_output
);
    import cpu_pkg::*;

    logic [data_width-1:0]     dmem [dmem_depth];
    logic [mem_addr_width-1:0] addr;

    assign addr = result[mem_addr_width-1:0];

    always_ff @(posedge clk) begin
        if (mem_write) begin
            dmem[addr] <= store_data;
        end
    end

    // Memory/writeback register.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= reg_write;
        end
    end

    always_ff @(posedge clk) begin
        wb_dest   <= dest;
        wb_output <= mem_read ? dmem[addr] : result;  // Load word or ALU result.
    end

endmodule

//--- hdl/pipelined_processor.sv
module pipelined_processor (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              run,
    input  logic                              prog_we,
    input  logic [cpu_pkg::mem_addr_width-1:0] prog_addr,
    input  logic [cpu_pkg::instr_width-1:0]    prog_data,
    output logic                              wb_valid,
    output logic [cpu_pkg::reg_addr_width-1:0] wb_dest,
    output logic [cpu_pkg::data_width-1:0]     wb_output
);
    import cpu_pkg::*;

    // Fetch to decode.
    logic [instr_width-1:0]    fd_instr;
    logic                      fd_valid;

    // Decode to execute.
    logic [data_width-1:0]     de_rs_data;
    logic [data_width-1:0]     de_rt_data;
    logic [data_width-1:0]     de_imm;
    alu_op_t                   de_alu_op;
    logic                      de_use_imm;
    logic                      de_mem_read;
    logic                      de_mem_write;
    logic                      de_reg_write;
    logic [reg_addr_width-1:0] de_dest;

    // Execute to memory.
    logic [data_width-1:0]     em_result;
    logic [data_width-1:0]     em_store_data;
    logic                      em_mem_read;
    logic                      em_mem_write;
    logic                      em_reg_write;
    logic [reg_addr_width-1:0] em_dest;

    // **************************************************
    // Stages
    // **************************************************
    fetch_stage fetch0 (
        .clk         (clk),
        .arst_n      (arst_n),
        .run         (run),
        .prog_we     (prog_we),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .instr       (fd_instr),
        .instr_valid (fd_valid)
    );

    decode_stage decode0 (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr       (fd_instr),
        .instr_valid (fd_valid),
        .wb_valid    (wb_valid),                      // Writeback loops back here.
        .wb_dest     (wb_dest),
        .wb_output   (wb_output),
        .rs_data     (de_rs_data),
        .rt_data     (de_rt_data),
        .imm         (de_imm),
        .alu_op      (de_alu_op),
        .use_imm     (de_use_imm),
        .mem_read    (de_mem_read),
        .mem_write   (de_mem_write),
        .reg_write   (de_reg_write),
        .dest        (de_dest)
    );

    alu_stage alu0 (
        .clk         (clk),
        .arst_n      (arst_n),
        .rs_data     (de_rs_data),
        .rt_data     (de_rt_data),
        .imm         (de_imm),
        .alu_op      (de_alu_op),
        .use_imm     (de_use_imm),
        .mem_read    (de_mem_read),
        .mem_write   (de_mem_write),
        .reg_write   (de_reg_write),
        .dest        (de_dest),
        .result      (em_result),
        .store_data  (em_store_data),
        .mem_read_q  (em_mem_read),
        .mem_write_q (em_mem_write),
        .reg_write_q (em_reg_write),
        .dest_q      (em_dest)
    );

    data_memory mem0 (
        .clk         (clk),
        .arst_n      (arst_n),
        .result      (em_result),
        .store_data  (em_store_data),
        .mem_read    (em_mem_read),
        .mem_write   (em_mem_write),
        .reg_write   (em_reg_write),
        .dest        (em_dest),
        .wb_valid    (wb_valid),
        .wb_dest     (wb_dest),
        .wb_output   (wb_output)
    );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f \
    --top-module tb_pipelined_processor -o sim_tb
./obj_dir/sim_tb +verilator+error+limit+1000 | tee sim.log

if grep -q 'Test failures found' sim.log; then
    echo "Simulation failed"
    exit 1
fi
if ! grep -q 'All tests passed!' sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"

//--- testbench/pipelined_processor_assertions.sv
module pipelined_processor_assertions (
    input logic                              clk,
    input logic                              arst_n,
    input logic                              run,
    input logic                              wb_valid,
    input logic [cpu_pkg::reg_addr_width-1:0] wb_dest,
    input logic [cpu_pkg::data_width-1:0]     wb_output
);
    logic [2:0]  since_start;                         // Edges since run was first seen high.
    logic [2:0]  run_low;                             // Consecutive edges with run low.
    int unsigned early_fails = 0;
    int unsigned drain_fails = 0;
    int unsigned unknown_fails = 0;
    int unsigned fail_count;

    assign fail_count = early_fails + drain_fails + unknown_fails;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            since_start <= '0;
            run_low     <= '0;
        end else begin
            if (since_start != 3'd7 && (run || since_start != 3'd0)) begin
                since_start <= since_start + 3'd1;
            end
            if (run) begin
                run_low <= '0;
            end else if (run_low != 3'd7) begin
                run_low <= run_low + 3'd1;
            end
        end
    end

    // **************************************************
    // Writeback rules
    // **************************************************
    early_wb: assert property (@(posedge clk) disable iff (!arst_n)
        wb_valid |-> since_start >= 3'd5)
    else begin
        $error("wb_valid before the first instruction could retire");
        early_fails++;
    end

    drained_wb: assert property (@(posedge clk) disable iff (!arst_n)
        run_low >= 3'd5 |-> !wb_valid)                // Pipeline is empty by then.
    else begin
        $error("wb_valid after the pipeline should have drained");
        drain_fails++;
    end

    known_wb: assert property (@(posedge clk) disable iff (!arst_n)
        wb_valid |-> !$isunknown({wb_dest, wb_output}))
    else begin
        $error("unknown bits on wb_dest or wb_output during a writeback");
        unknown_fails++;
    end

endmodule

bind pipelined_processor pipelined_processor_assertions chk0 (
    .clk       (clk),
    .arst_n    (arst_n),
    .run       (run),
    .wb_valid  (wb_valid),
    .wb_dest   (wb_dest),
    .wb_output (wb_output)
);

//--- testbench/tb_pipelined_processor.sv
module tb_pipelined_processor;
    import cpu_pkg::*;

    logic                      clk = 1'b0;
    logic                      arst_n;
    logic                      run;
    logic                      prog_we;
    logic [mem_addr_width-1:0] prog_addr;
    logic [instr_width-1:0]    prog_data;
    logic                      wb_valid;
    logic [reg_addr_width-1:0] wb_dest;
    logic [data_width-1:0]     wb_output;

    logic [15:0] prog [$];
    logic [2:0]  exp_dest [$];
    logic [15:0] exp_val [$];
    logic [15:0] m_regs [8];
    logic [15:0] m_mem [256];
    int          value_errors = 0;
    int          strobe_errors = 0;
    int          flow_errors = 0;

    pipelined_processor dut0 (
        .clk(clk), .arst_n(arst_n), .run(run), .prog_we(prog_we), .prog_addr(prog_addr),
        .prog_data(prog_data), .wb_valid(wb_valid), .wb_dest(wb_dest), .wb_output(wb_output)
    );

    always #5 clk = ~clk;

    // Scoreboard samples mid-cycle.
    always @(negedge clk) begin
        if (arst_n && wb_valid) begin
            if (exp_dest.size() == 0) begin
                $display("%0t: writeback to r%0d when no result was expected", $time, wb_dest);
                strobe_errors++;
            end else begin
                assert (wb_dest === exp_dest[0]) else begin
                    $display("[ERROR] %0t wb_dest expected %0d got %0d",
                             $time, exp_dest[0], wb_dest);
                    value_errors++;
                end
                assert (wb_output === exp_val[0]) else begin
                    $display("[ERROR] %0t wb_output expected %h got %h",
                             $time, exp_val[0], wb_output);
                    value_errors++;
                end
                void'(exp_dest.pop_front());
                void'(exp_val.pop_front());
            end
        end
    end

    // **************************************************
    // Program assembly and model
    // **************************************************
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic emit(input logic [15:0] w);
        prog.push_back(w);
        prog.push_back(nop_instr);                    // Keeps dependents three slots apart.
        prog.push_back(nop_instr);
    endtask

    function automatic logic [15:0] alu_word(input logic [3:0] op, input int rd,
                                             input int rs, input int rt);
        return {op, rd[2:0], rs[2:0], rt[2:0], 3'b000};
    endfunction

    function automatic logic [15:0] ldi_word(input int rd, input int imm);
        return {op_ldi, rd[2:0], imm[8:0]};
    endfunction

    task automatic model_program(input int n);
        logic [15:0] w;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] r;
        logic        writes;
        for (int i = 0; i < n; i++) begin
            w      = prog[i];
            a      = m_regs[w[8:6]];
            b      = m_regs[w[5:3]];
            r      = '0;
            writes = 1'b1;
            case (w[15:12])
                op_add:  r = a + b;
                op_sub:  r = a - b;
                op_and:  r = a & b;
                op_or:   r = a | b;
                op_xor:  r = a ^ b;
                op_not:  r = ~a;
                op_shl:  r = a << b[3:0];
                op_shr:  r = a >> b[3:0];
                op_ldi:  r = {7'd0, w[8:0]};
                op_ld:   r = m_mem[a[7:0]];
                op_st: begin
                    m_mem[a[7:0]] = b;
                    writes        = 1'b0;
                end
                default: writes = 1'b0;
            endcase
            if (writes) begin
                m_regs[w[11:9]] = r;
                exp_dest.push_back(w[11:9]);
                exp_val.push_back(r);
            end
        end
    endtask

    task automatic gen_random(input int count);
        int unsigned kind;
        int          ra;
        int          addr;
        int          stored [$];
        prog.delete();
        emit(ldi_word($urandom % 8, $urandom % 512));
        for (int i = 1; i < count; i++) begin
            kind = $urandom % 11;
            ra   = $urandom % 8;
            addr = $urandom % 256;
            if (kind == 10 && stored.size() == 0) begin
                kind = 9;                             // Nothing stored yet to load.
            end else if (kind == 10) begin
                addr = stored[$urandom % stored.size()];
            end
            if (kind == 0) begin
                emit(ldi_word($urandom % 8, $urandom % 512));
            end else if (kind <= 8) begin
                emit(alu_word(4'(kind), $urandom % 8, $urandom % 8, $urandom % 8)); // ADD to SHR.
            end else begin
                emit(ldi_word(ra, addr));
                if (kind == 9) begin
                    emit(alu_word(op_st, 0, ra, $urandom % 8));
                    stored.push_back(addr);
                end else begin
                    emit(alu_word(op_ld, $urandom % 8, ra, 0));
                end
            end
        end
    endtask

    // **************************************************
    // Run control
    // **************************************************
    task automatic load_program();
        for (int a = 0; a < imem_depth; a++) begin
            step();
            prog_we   = 1'b1;
            prog_addr = a[7:0];
            prog_data = (a < prog.size()) ? prog[a] : {op_nop, 4'h0, a[7:0]};
        end
        step();
        prog_we = 1'b0;
    endtask

    task automatic wait_retired(input int limit);
        int n;
        n = 0;
        while (exp_dest.size() != 0 && n < limit) begin
            @(posedge clk);
            n++;
        end
        if (exp_dest.size() != 0) begin
            $display("Timeout: %0d results never reached writeback", exp_dest.size());
            flow_errors++;
        end
    endtask

    task automatic check_latency();
        int n;
        n = 0;
        while (n < 20) begin
            @(negedge clk);
            if (wb_valid) begin
                break;
            end
            n++;
        end
        if (!wb_valid) begin
            $display("Timeout: no writeback after run was raised");
            flow_errors++;
        end else begin
            assert (n == 5) else begin
                $display("[ERROR] %0t wb_valid latency expected 5 got %0d", $time, n);
                flow_errors++;
            end
        end
    endtask

    // A hold of zero runs the whole program. Otherwise run stays high for hold edges.
    task automatic run_program(input int hold);
        load_program();
        model_program(hold > 0 ? hold - 1 : prog.size());
        run = 1'b1;
        if (hold > 0) begin
            repeat (hold) @(posedge clk);
            #1;
            run = 1'b0;
            wait_retired(20);
        end else begin
            check_latency();
            wait_retired(400);
            #1;
            run = 1'b0;
        end
        repeat (12) step();                           // Any late strobe hits the scoreboard.
    endtask

    initial begin
        void'($urandom(92649));
        arst_n    = 1'b0;
        run       = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        for (int i = 0; i < 8; i++) begin
            m_regs[i] = '0;
        end
        repeat (16) @(posedge clk);
        #1;
        arst_n = 1'b1;
        repeat (4) step();

        prog.delete();
        emit(ldi_word(1, 9'h1a5));
        emit(ldi_word(2, 9'h0f3));
        emit(ldi_word(3, 5));
        emit(alu_word(op_add, 4, 1, 2));
        emit(alu_word(op_sub, 5, 2, 1));              // Wraps below zero.
        emit(alu_word(op_and, 6, 1, 2));
        emit(alu_word(op_or, 7, 1, 2));
        emit(alu_word(op_xor, 0, 1, 2));
        emit(alu_word(op_not, 4, 1, 0));
        emit(alu_word(op_shl, 5, 1, 3));
        emit(alu_word(op_shr, 6, 1, 3));
        run_program(0);

        prog.delete();
        emit(ldi_word(1, 8'h40));
        emit(ldi_word(2, 9'h123));
        emit(alu_word(op_st, 0, 1, 2));
        emit(alu_word(op_ld, 3, 1, 0));
        run_program(0);

        gen_random(40);
        run_program(0);
        run_program(prog.size() / 2);                 // Stop halfway, then restart at 0.
        run_program(0);

        $display("Errors: %0d value, %0d unexpected strobe, %0d flow, %0d assertion",
                 value_errors, strobe_errors, flow_errors, dut0.chk0.fail_count);
        if (value_errors + strobe_errors + flow_errors + int'(dut0.chk0.fail_count) == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- verilog.f
common/cpu_pkg.sv
fetch/fetch_stage.sv
decode/register_file.sv
decode/decode_stage.sv
hdl/alu_stage.sv
hdl/data_memory.sv
hdl/pipelined_processor.sv
testbench/pipelined_processor_assertions.sv
testbench/tb_pipelined_processor.sv
